// File: src/counter_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, register map and types for the counter
// peripheral. Modules refer to these by scoped name.
////////////////////////////////////////////////////////////

package counter_pkg;

    // Widths
    localparam int COUNT_W = 16;
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 4;

    typedef logic [COUNT_W-1:0] count_t;    // Count or load value
    typedef logic [DATA_W-1:0]  axi_data_t;
    typedef logic [ADDR_W-1:0]  axi_addr_t; // Byte address

    // Register byte offsets
    localparam axi_addr_t REG_CTRL   = 4'h0;
    localparam axi_addr_t REG_LOAD   = 4'h4;
    localparam axi_addr_t REG_COUNT  = 4'h8;
    localparam axi_addr_t REG_STATUS = 4'hC;

    // CTRL register bits
    localparam int CTRL_RUN    = 0;
    localparam int CTRL_DOWN   = 1; // 1 counts down
    localparam int CTRL_IRQ_EN = 2;
    localparam int CTRL_LOAD   = 3; // Write 1 requests a load, reads pending flag

    // STATUS register bits, write 1 to clear
    localparam int ST_OVF = 0;
    localparam int ST_UNF = 1;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Counter control states
    typedef enum logic [1:0] {
        IDLE,
        COUNT,
        UNDERFLOW,
        OVERFLOW
    } ctrl_state_e;

endpackage

// File: src/count_datapath.sv
////////////////////////////////////////////////////////////
// Count register for the peripheral. Applies the command
// from the control FSM and keeps a registered output copy.
////////////////////////////////////////////////////////////

module count_datapath (
    input  logic                clk,
    input  logic                rst,
    input  counter_pkg::count_t load_value,
    input  logic                do_load,
    input  logic                do_inc,
    input  logic                do_dec,
    input  logic                wrap_zero,
    input  logic                wrap_max,
    output counter_pkg::count_t count_value,
    output logic                at_zero,
    output logic                at_max
);

    counter_pkg::count_t count;

    // Only one command arrives per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            if (do_load)
                count <= load_value;
            else if (wrap_zero)
                count <= '0;
            else if (wrap_max)
                count <= '1;
            else if (do_inc)
                count <= count + 1'b1;
            else if (do_dec)
                count <= count - 1'b1;
        end
    end

    // Output lags the internal count by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            count_value <= '0;
        else
            count_value <= count;
    end

    // Boundary flags from the live count
    assign at_zero = (count == '0);
    assign at_max  = (count == '1); // All ones

endmodule

// File: src/count_ctrl.sv
////////////////////////////////////////////////////////////
// Counter control FSM. Sequences load, count steps, wrap
// and event pulses as one-cycle datapath commands.
////////////////////////////////////////////////////////////

module count_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic down,
    input  logic load_pending,
    input  logic at_zero,
    input  logic at_max,
    output logic load_ack,
    output logic do_load,
    output logic do_inc,
    output logic do_dec,
    output logic wrap_zero,
    output logic wrap_max,
    output logic ovf_pulse,
    output logic unf_pulse
);

    counter_pkg::ctrl_state_e state, state_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= counter_pkg::IDLE;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        load_ack   = 1'b0;
        do_load    = 1'b0;
        do_inc     = 1'b0;
        do_dec     = 1'b0;
        wrap_zero  = 1'b0;
        wrap_max   = 1'b0;
        ovf_pulse  = 1'b0;
        unf_pulse  = 1'b0;
        case (state)
            counter_pkg::IDLE: begin
                if (load_pending) begin // Load before start
                    do_load  = 1'b1;
                    load_ack = 1'b1;
                end else if (run) begin
                    state_next = counter_pkg::COUNT;
                end
            end
            counter_pkg::COUNT: begin
                if (!run) begin
                    state_next = counter_pkg::IDLE;
                end else if (!down) begin
                    if (at_max) begin   // Leaving the top wraps to zero
                        wrap_zero  = 1'b1;
                        ovf_pulse  = 1'b1;
                        state_next = counter_pkg::OVERFLOW;
                    end else begin
                        do_inc = 1'b1;
                    end
                end else if (at_zero) begin
                    wrap_max   = 1'b1;
                    unf_pulse  = 1'b1;
                    state_next = counter_pkg::UNDERFLOW;
                end else begin
                    do_dec = 1'b1;
                end
            end
            counter_pkg::UNDERFLOW, counter_pkg::OVERFLOW: state_next = counter_pkg::IDLE;
            default: state_next = counter_pkg::IDLE;
        endcase
    end

    // An event is followed by a quiet cycle before the next one
    a_evt_exclusive: assert property (@(posedge clk) disable iff (rst)
        (ovf_pulse || unf_pulse) |-> !(ovf_pulse && unf_pulse) ##1 !(ovf_pulse || unf_pulse));
    a_step_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(do_inc && do_dec));

endmodule

// File: src/event_status.sv
////////////////////////////////////////////////////////////
// Sticky overflow and underflow flags with write-1-to-clear
// and the interrupt output.
////////////////////////////////////////////////////////////

module event_status (
    input  logic       clk,
    input  logic       rst,
    input  logic       ovf_pulse,
    input  logic       unf_pulse,
    input  logic [1:0] clear_mask,
    input  logic       irq_en,
    output logic       status_ovf,
    output logic       status_unf,
    output logic       irq
);

    // A new event outranks a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status_ovf <= 1'b0;
            status_unf <= 1'b0;
        end else begin
            if (ovf_pulse)
                status_ovf <= 1'b1;
            else if (clear_mask[counter_pkg::ST_OVF])
                status_ovf <= 1'b0;

            if (unf_pulse)
                status_unf <= 1'b1;
            else if (clear_mask[counter_pkg::ST_UNF])
                status_unf <= 1'b0;
        end
    end

    // Level interrupt while any flag is set
    assign irq = irq_en && (status_ovf || status_unf);

endmodule

// File: src/axil_reg_slave.sv
////////////////////////////////////////////////////////////
// AXI4-Lite register slave for the counter peripheral.
// Holds CTRL, LOAD and the pending load request, and
// returns count and sticky status on reads.
////////////////////////////////////////////////////////////

module axil_reg_slave (
    input  logic                  clk,
    input  logic                  rst,
    // Write address
    input  logic                  awvalid,
    output logic                  awready,
    input  counter_pkg::axi_addr_t awaddr,
    // Write data
    input  logic                  wvalid,
    output logic                  wready,
    input  counter_pkg::axi_data_t wdata,
    // Write response
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    // Read address
    input  logic                  arvalid,
    output logic                  arready,
    input  counter_pkg::axi_addr_t araddr,
    // Read data
    output logic                  rvalid,
    input  logic                  rready,
    output counter_pkg::axi_data_t rdata,
    output logic [1:0]            rresp,
    // Core side
    input  counter_pkg::count_t   count_value,
    input  logic                  status_ovf,
    input  logic                  status_unf,
    input  logic                  load_ack,
    output logic                  run,
    output logic                  down,
    output logic                  irq_en,
    output logic                  load_pending,
    output counter_pkg::count_t   load_value,
    output logic [1:0]            clear_mask
);

    logic                   wr_fire;
    logic                   rd_fire;
    counter_pkg::axi_data_t rd_mux;

    // Address and data taken together, only with no response waiting
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign rd_fire = arvalid && !rvalid;

    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = rd_fire;
    assign bresp   = counter_pkg::RESP_OKAY;
    assign rresp   = counter_pkg::RESP_OKAY; // Unmapped reads are OKAY too

    // Register writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run          <= 1'b0;
            down         <= 1'b0;
            irq_en       <= 1'b0;
            load_pending <= 1'b0;
            load_value   <= '0;
        end else begin
            if (load_ack)
                load_pending <= 1'b0;
            if (wr_fire) begin
                case (awaddr)
                    counter_pkg::REG_CTRL: begin
                        run    <= wdata[counter_pkg::CTRL_RUN];
                        down   <= wdata[counter_pkg::CTRL_DOWN];
                        irq_en <= wdata[counter_pkg::CTRL_IRQ_EN];
                        if (wdata[counter_pkg::CTRL_LOAD])
                            load_pending <= 1'b1; // New request beats an ack
                    end
                    counter_pkg::REG_LOAD: load_value <= wdata[counter_pkg::COUNT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // One-cycle clear toward the status block
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            clear_mask <= 2'b00;
        else if (wr_fire && awaddr == counter_pkg::REG_STATUS)
            clear_mask <= {wdata[counter_pkg::ST_UNF], wdata[counter_pkg::ST_OVF]};
        else
            clear_mask <= 2'b00;
    end

    // Write response channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            bvalid <= 1'b0;
        else if (wr_fire)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

    // Read data selection
    always_comb begin
        rd_mux = '0;
        case (araddr)
            counter_pkg::REG_CTRL: begin
                rd_mux[counter_pkg::CTRL_RUN]    = run;
                rd_mux[counter_pkg::CTRL_DOWN]   = down;
                rd_mux[counter_pkg::CTRL_IRQ_EN] = irq_en;
                rd_mux[counter_pkg::CTRL_LOAD]   = load_pending;
            end
            counter_pkg::REG_LOAD:  rd_mux[counter_pkg::COUNT_W-1:0] = load_value;
            counter_pkg::REG_COUNT: rd_mux[counter_pkg::COUNT_W-1:0] = count_value;
            counter_pkg::REG_STATUS: begin
                rd_mux[counter_pkg::ST_OVF] = status_ovf;
                rd_mux[counter_pkg::ST_UNF] = status_unf;
            end
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_fire)
            rdata <= rd_mux;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rvalid <= 1'b0;
        else if (rd_fire)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // Responses stay up until the master takes them
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid);
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: src/counter_periph_top.sv
////////////////////////////////////////////////////////////
// Counter peripheral top. AXI4-Lite register slave around
// the count FSM, its datapath and the event status block.
////////////////////////////////////////////////////////////

module counter_periph_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   awvalid,
    output logic                   awready,
    input  counter_pkg::axi_addr_t awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  counter_pkg::axi_data_t wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  counter_pkg::axi_addr_t araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output counter_pkg::axi_data_t rdata,
    output logic [1:0]             rresp,
    output logic                   irq
);

    counter_pkg::count_t count_value, load_value;
    logic                run, down, irq_en, load_pending, load_ack;
    logic                status_ovf, status_unf;
    logic [1:0]          clear_mask;
    logic                do_load, do_inc, do_dec, wrap_zero, wrap_max;
    logic                at_zero, at_max, ovf_pulse, unf_pulse;

    axil_reg_slave i_axil_reg_slave (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .count_value(count_value), .status_ovf(status_ovf), .status_unf(status_unf),
        .load_ack(load_ack), .run(run), .down(down), .irq_en(irq_en),
        .load_pending(load_pending), .load_value(load_value), .clear_mask(clear_mask)
    );

    count_ctrl i_count_ctrl (
        .clk(clk), .rst(rst), .run(run), .down(down), .load_pending(load_pending),
        .at_zero(at_zero), .at_max(at_max), .load_ack(load_ack), .do_load(do_load),
        .do_inc(do_inc), .do_dec(do_dec), .wrap_zero(wrap_zero), .wrap_max(wrap_max),
        .ovf_pulse(ovf_pulse), .unf_pulse(unf_pulse)
    );

    count_datapath i_count_datapath (
        .clk(clk), .rst(rst), .load_value(load_value), .do_load(do_load),
        .do_inc(do_inc), .do_dec(do_dec), .wrap_zero(wrap_zero), .wrap_max(wrap_max),
        .count_value(count_value), .at_zero(at_zero), .at_max(at_max)
    );

    event_status i_event_status (
        .clk(clk), .rst(rst), .ovf_pulse(ovf_pulse), .unf_pulse(unf_pulse),
        .clear_mask(clear_mask), .irq_en(irq_en),
        .status_ovf(status_ovf), .status_unf(status_unf), .irq(irq)
    );

endmodule

// File: testbench/tb_axil_tasks.svh
////////////////////////////////////////////////////////////
// AXI4-Lite master tasks, LFSR and compare helpers for the
// counter testbench. Included inside the testbench module.
////////////////////////////////////////////////////////////

`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Compare one value and log a mismatch
task automatic check(input string label, input logic [31:0] expected,
                     input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        test_errors++;
        $display("FAIL %s %s: expected 0x%0h, actual 0x%0h",
                 test_name, label, expected, actual);
    end
endtask

task automatic report_error(input string msg);
    errors++;
    test_errors++;
    $display("ERROR in %s: %s", test_name, msg);
endtask

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0])
        return (state >> 1) ^ 16'hB400;
    return state >> 1;
endfunction

task automatic draw_bits(input int nbits, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
        lfsr_state = lfsr_next(lfsr_state); // One step per bit
        value      = {value[14:0], lfsr_state[0]};
    end
endtask

// Write with optional bready hold-off
task automatic write_reg(input counter_pkg::axi_addr_t addr,
                         input counter_pkg::axi_data_t data, input int hold = 0);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
        @(posedge clk); // Handshake completes on this edge
    end while (!(awready && wready));
    @(negedge clk);
    // Response now waiting, so the slave must refuse a new write
    check("awready while bvalid waits", 32'(1'b0), 32'(awready));
    check("wready while bvalid waits", 32'(1'b0), 32'(wready));
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check("bvalid after accept", 32'(1'b1), 32'(bvalid));
    check("bresp", 32'(counter_pkg::RESP_OKAY), 32'(bresp));
    repeat (hold) begin
        @(negedge clk);
        check("bvalid held", 32'(1'b1), 32'(bvalid));
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    check("bvalid after bready", 32'(1'b0), 32'(bvalid));
endtask

// Read with optional rready hold-off
task automatic read_reg(input counter_pkg::axi_addr_t addr,
                        output counter_pkg::axi_data_t data, input int hold = 0);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    do begin
        @(posedge clk); // Handshake completes on this edge
    end while (!arready);
    @(negedge clk);
    check("arready while rvalid waits", 32'(1'b0), 32'(arready));
    arvalid = 1'b0;
    check("rvalid after accept", 32'(1'b1), 32'(rvalid));
    data    = rdata;
    check("rresp", 32'(counter_pkg::RESP_OKAY), 32'(rresp));
    repeat (hold) begin
        @(negedge clk);
        check("rvalid held", 32'(1'b1), 32'(rvalid));
        check("rdata held", data, rdata);
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    check("rvalid after rready", 32'(1'b0), 32'(rvalid));
endtask

`endif

// File: testbench/tb_counter_periph.sv
////////////////////////////////////////////////////////////
// Testbench for the counter peripheral. Drives the AXI4-Lite
// port, polls registers and checks status against a model.
////////////////////////////////////////////////////////////

module tb_counter_periph;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 10;
    localparam logic [15:0] LFSR_SEED    = 16'd4895;
    localparam int          POLL_LIMIT   = 50;
    // Test lengths in clock cycles
    localparam int LEN_REGS  = 200;
    localparam int LEN_LOAD  = 120;
    localparam int LEN_COUNT = 400;
    localparam int LEN_WRAP  = 300;
    localparam int LEN_CLEAR = 300;
    localparam int WATCHDOG_NS = (RESET_CYCLES + LEN_REGS + LEN_LOAD + LEN_COUNT
                                  + LEN_WRAP + LEN_CLEAR) * 2 * CLK_PERIOD;
    localparam logic [31:0] OVF_BIT = 32'(1) << counter_pkg::ST_OVF;
    localparam logic [31:0] UNF_BIT = 32'(1) << counter_pkg::ST_UNF;

    logic                   clk, rst;
    logic                   awvalid, awready, wvalid, wready, bvalid, bready;
    logic                   arvalid, arready, rvalid, rready, irq;
    counter_pkg::axi_addr_t awaddr, araddr;
    counter_pkg::axi_data_t wdata, rdata;
    logic [1:0]             bresp, rresp;

    string       test_name;
    int          errors, test_errors, checks, tests_done;
    logic [15:0] lfsr_state;

    // Operands handed to the status compare process
    event        status_sample;
    logic [15:0] ref_start, ref_count;
    logic        ref_down;
    logic [1:0]  obs_status;

    `include "tb_axil_tasks.svh"

    counter_periph_top i_counter_periph_top (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .irq(irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Flag expected from where the count ended relative to its start
    function automatic logic [1:0] expected_status(input logic [15:0] start, input logic down,
                                                   input logic [15:0] observed);
        logic [1:0] flags;
        flags = 2'b00;
        if (!down && observed < start)
            flags[counter_pkg::ST_OVF] = 1'b1; // Passed the top and wrapped
        else if (down && observed > start)
            flags[counter_pkg::ST_UNF] = 1'b1;
        return flags;
    endfunction

    always @(status_sample)
        check("status", 32'(expected_status(ref_start, ref_down, ref_count)), 32'(obs_status));

    function automatic counter_pkg::axi_data_t ctrl_word(input logic run, input logic down,
                                                         input logic irq_en, input logic load);
        counter_pkg::axi_data_t word;
        word = '0;
        word[counter_pkg::CTRL_RUN]    = run;
        word[counter_pkg::CTRL_DOWN]   = down;
        word[counter_pkg::CTRL_IRQ_EN] = irq_en;
        word[counter_pkg::CTRL_LOAD]   = load;
        return word;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        @(negedge clk); // Let the compare process settle
        tests_done++;
        $display("Test %s done, %0d mismatches", test_name, test_errors);
    endtask

    // Request a load with run low and wait until the FSM takes it
    task automatic load_counter(input logic [15:0] value, input counter_pkg::axi_data_t ctrl);
        counter_pkg::axi_data_t data;
        int                     polls;
        write_reg(counter_pkg::REG_LOAD, 32'(value));
        write_reg(counter_pkg::REG_CTRL, ctrl | ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        polls = 0;
        do begin
            read_reg(counter_pkg::REG_CTRL, data);
            polls++;
        end while (data[counter_pkg::CTRL_LOAD] && polls < POLL_LIMIT);
        if (data[counter_pkg::CTRL_LOAD])
            report_error("load request still pending after polling CTRL");
    endtask

    task automatic run_until_flag(input counter_pkg::axi_data_t ctrl, input int flag);
        counter_pkg::axi_data_t data;
        int                     polls;
        write_reg(counter_pkg::REG_CTRL, ctrl | ctrl_word(1'b1, 1'b0, 1'b0, 1'b0));
        polls = 0;
        do begin
            read_reg(counter_pkg::REG_STATUS, data);
            polls++;
        end while (!data[flag] && polls < POLL_LIMIT);
        write_reg(counter_pkg::REG_CTRL, ctrl); // Stop, keep irq_en
        if (!data[flag])
            report_error("expected status flag never set while counting");
    endtask

    // Read the frozen count and status, then hand both to the compare process
    task automatic compare_status(input logic [15:0] start, input logic down,
                                  output logic [15:0] count);
        counter_pkg::axi_data_t data;
        read_reg(counter_pkg::REG_COUNT, data);
        count = data[15:0];
        read_reg(counter_pkg::REG_STATUS, data);
        ref_start  = start;
        ref_down   = down;
        ref_count  = count;
        obs_status = data[1:0];
        -> status_sample;
        @(negedge clk);
    endtask

    task automatic registers_test();
        counter_pkg::axi_data_t data;
        logic [15:0]            value;
        start_test("registers");
        read_reg(counter_pkg::REG_CTRL, data);
        check("CTRL after reset", 32'h0, data);
        read_reg(counter_pkg::REG_LOAD, data);
        check("LOAD after reset", 32'h0, data);
        read_reg(counter_pkg::REG_COUNT, data);
        check("COUNT after reset", 32'h0, data);
        read_reg(counter_pkg::REG_STATUS, data);
        check("STATUS after reset", 32'h0, data);
        read_reg(4'h2, data, 2);    // Unmapped
        check("unmapped read", 32'h0, data);
        write_reg(counter_pkg::REG_CTRL, ctrl_word(1'b0, 1'b1, 1'b1, 1'b0), 3);
        read_reg(counter_pkg::REG_CTRL, data);
        check("CTRL readback", ctrl_word(1'b0, 1'b1, 1'b1, 1'b0), data);
        draw_bits(16, value);
        write_reg(counter_pkg::REG_LOAD, 32'(value));
        read_reg(counter_pkg::REG_LOAD, data, 2);
        check("LOAD readback", 32'(value), data);
        write_reg(4'h6, 32'hFFFF_FFFF, 1);
        read_reg(counter_pkg::REG_CTRL, data);
        check("CTRL after unmapped write", ctrl_word(1'b0, 1'b1, 1'b1, 1'b0), data);
        write_reg(counter_pkg::REG_CTRL, 32'h0);
        finish_test();
    endtask

    task automatic load_test();
        counter_pkg::axi_data_t first, second;
        logic [15:0]            value;
        start_test("load");
        draw_bits(16, value);
        load_counter(value, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0));
        read_reg(counter_pkg::REG_COUNT, first);
        check("COUNT after load", 32'(value), first);
        read_reg(counter_pkg::REG_COUNT, first);
        read_reg(counter_pkg::REG_COUNT, second);
        check("COUNT frozen", first, second);
        finish_test();
    endtask

    task automatic count_test();
        counter_pkg::axi_data_t data;
        logic [15:0]            start, count;
        logic                   down;
        start_test("count_up_down");
        for (int dir = 0; dir < 2; dir++) begin
            down = dir[0];
            draw_bits(14, start);
            start = start + 16'h2000;   // Mid range, far from both ends
            load_counter(start, ctrl_word(1'b0, down, 1'b0, 1'b0));
            write_reg(counter_pkg::REG_STATUS, OVF_BIT | UNF_BIT);
            write_reg(counter_pkg::REG_CTRL, ctrl_word(1'b1, down, 1'b0, 1'b0));
            repeat (12)
                read_reg(counter_pkg::REG_COUNT, data);
            write_reg(counter_pkg::REG_CTRL, ctrl_word(1'b0, down, 1'b0, 1'b0));
            compare_status(start, down, count);
            check("count direction", 32'(1'b1), 32'(down ? (count < start) : (count > start)));
        end
        finish_test();
    endtask

    task automatic wrap_test();
        logic [15:0] count;
        start_test("wrap");
        // Top value upward with irq enabled
        write_reg(counter_pkg::REG_STATUS, OVF_BIT | UNF_BIT);
        load_counter(16'hFFFF, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0));
        run_until_flag(ctrl_word(1'b0, 1'b0, 1'b1, 1'b0), counter_pkg::ST_OVF);
        compare_status(16'hFFFF, 1'b0, count);
        check("irq enabled", 32'(1'b1), 32'(irq));
        // Zero downward with irq masked
        write_reg(counter_pkg::REG_STATUS, OVF_BIT | UNF_BIT);
        load_counter(16'h0000, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0));
        run_until_flag(ctrl_word(1'b0, 1'b1, 1'b0, 1'b0), counter_pkg::ST_UNF);
        compare_status(16'h0000, 1'b1, count);
        check("irq masked", 32'(1'b0), 32'(irq));
        finish_test();
    endtask

    task automatic clear_test();
        counter_pkg::axi_data_t data;
        start_test("clear");
        write_reg(counter_pkg::REG_STATUS, OVF_BIT | UNF_BIT);
        load_counter(16'hFFFF, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0));
        run_until_flag(ctrl_word(1'b0, 1'b0, 1'b1, 1'b0), counter_pkg::ST_OVF);
        load_counter(16'h0000, ctrl_word(1'b0, 1'b1, 1'b1, 1'b0));
        run_until_flag(ctrl_word(1'b0, 1'b1, 1'b1, 1'b0), counter_pkg::ST_UNF);
        read_reg(counter_pkg::REG_STATUS, data);
        check("both flags set", OVF_BIT | UNF_BIT, data);
        check("irq with both flags", 32'(1'b1), 32'(irq));
        write_reg(counter_pkg::REG_STATUS, OVF_BIT);
        read_reg(counter_pkg::REG_STATUS, data);
        check("overflow cleared only", UNF_BIT, data);
        check("irq with underflow left", 32'(1'b1), 32'(irq));
        write_reg(counter_pkg::REG_STATUS, UNF_BIT);
        read_reg(counter_pkg::REG_STATUS, data);
        check("all flags cleared", 32'h0, data);
        check("irq after clear", 32'(1'b0), 32'(irq));
        finish_test();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        lfsr_state = LFSR_SEED;
        errors     = 0;
        checks     = 0;
        tests_done = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        registers_test();
        load_test();
        count_test();
        wrap_test();
        clear_test();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+testbench
src/counter_pkg.sv
src/count_datapath.sv
src/count_ctrl.sv
src/event_status.sv
src/axil_reg_slave.sv
src/counter_periph_top.sv
testbench/tb_counter_periph.sv

// File: Makefile
TOP = tb_counter_periph

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
